// File: files.f
rtl/mipsPkg.sv
rtl/aluUnit.sv
rtl/registerFile.sv
rtl/mipsDatapath.sv
rtl/mipsController.sv
rtl/mipsCore.sv
testbench/mipsCore_assertions.sv
testbench/mipsCoreTb.sv

// File: rtl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
   input  wire mipsPkg::word_t  a,
   input  wire mipsPkg::word_t  b,
   input  wire mipsPkg::aluOp_t op,
   output mipsPkg::word_t       result,
   output logic                 zero
);

   logic           subtract;
   mipsPkg::word_t bOperand;
   logic [32:0]    sum;
   logic           overflow;
   logic           lessSigned;
   logic           lessUnsigned;

   // every op except add goes through the subtractor
   assign subtract = (op != mipsPkg::ALU_ADD);
   assign bOperand = subtract ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, bOperand} + {32'b0, subtract};

   // operands agree in sign but the sum does not
   assign overflow     = (a[31] == bOperand[31]) && (sum[31] != a[31]);
   assign lessSigned   = sum[31] ^ overflow;
   assign lessUnsigned = ~sum[32];   // borrow out of a - b

   always_comb begin
      case (op)
         mipsPkg::ALU_ADD,
         mipsPkg::ALU_SUB:  result = sum[31:0];
         mipsPkg::ALU_SLT:  result = {31'b0, lessSigned};
         mipsPkg::ALU_SLTU: result = {31'b0, lessUnsigned};
         mipsPkg::ALU_AND:  result = a & b;
         mipsPkg::ALU_XOR:  result = a ^ b;
         mipsPkg::ALU_OR:   result = a | b;
         default:           result = ~(a | b);   // nor
      endcase
   end

   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: rtl/mipsController.sv
`timescale 1ns/1ps
`default_nettype none

module mipsController (
   input  wire                    clk,
   input  wire                    reset,
   input  wire mipsPkg::opcode_t  opcode,
   input  wire mipsPkg::funct_t   funct,
   input  wire                    aluZero,
   output logic                   pcWrite,
   output logic                   pcFromJump,
   output logic                   irWrite,
   output logic                   mdrWrite,
   output logic                   marWrite,
   output logic                   aWrite,
   output logic                   bWrite,
   output logic                   regWrite,
   output logic                   addrFromAlu,
   output logic                   aluSelA,
   output mipsPkg::aluBSel_t      aluSelB,
   output mipsPkg::aluOp_t        aluOp,
   output logic                   signExtend,
   output logic                   regDstRd,
   output logic                   writeFromMem,
   output logic                   writeUpperImm,
   output logic                   memRead,
   output logic                   memWrite
);

   typedef enum logic [4:0] {
      S_FETCH0, S_FETCH1, S_FETCH2, S_FETCH3, S_DECODE,
      S_ALU_R, S_ALU_I,
      S_LOAD1, S_LOAD2, S_LOAD3, S_LOAD4, S_LOAD5,
      S_STORE1, S_STORE2,
      S_BRANCH_CMP, S_BRANCH_TGT, S_JUMP
   } ctrlState_t;

   ctrlState_t      state, nextState;
   logic            setRead, clrRead, setWrite, clrWrite;
   mipsPkg::aluOp_t functOp, immOp;
   logic            functKnown, immSigned;

   // ====================================================================
   // field decode
   // ====================================================================
   always_comb begin
      functOp    = mipsPkg::ALU_ADD;
      functKnown = 1'b1;
      case (funct)
         mipsPkg::FN_ADD, mipsPkg::FN_ADDU: functOp = mipsPkg::ALU_ADD;
         mipsPkg::FN_SUB, mipsPkg::FN_SUBU: functOp = mipsPkg::ALU_SUB;
         mipsPkg::FN_AND:  functOp = mipsPkg::ALU_AND;
         mipsPkg::FN_OR:   functOp = mipsPkg::ALU_OR;
         mipsPkg::FN_XOR:  functOp = mipsPkg::ALU_XOR;
         mipsPkg::FN_NOR:  functOp = mipsPkg::ALU_NOR;
         mipsPkg::FN_SLT:  functOp = mipsPkg::ALU_SLT;
         mipsPkg::FN_SLTU: functOp = mipsPkg::ALU_SLTU;
         default:          functKnown = 1'b0;
      endcase
   end

   // logic immediates are zero extended, the rest sign extended
   always_comb begin
      immOp     = mipsPkg::ALU_ADD;
      immSigned = 1'b1;
      case (opcode)
         mipsPkg::OP_SLTI:  immOp = mipsPkg::ALU_SLT;
         mipsPkg::OP_SLTIU: immOp = mipsPkg::ALU_SLTU;
         mipsPkg::OP_ANDI: begin
            immOp     = mipsPkg::ALU_AND;
            immSigned = 1'b0;
         end
         mipsPkg::OP_ORI: begin
            immOp     = mipsPkg::ALU_OR;
            immSigned = 1'b0;
         end
         mipsPkg::OP_XORI: begin
            immOp     = mipsPkg::ALU_XOR;
            immSigned = 1'b0;
         end
         default: ;   // addi, addiu, lui add
      endcase
   end

   // ====================================================================
   // state and memory strobes
   // ====================================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= S_FETCH0;
         memRead  <= 1'b0;
         memWrite <= 1'b0;
      end else begin
         state <= nextState;
         if (clrRead)
            memRead <= 1'b0;
         else if (setRead)
            memRead <= 1'b1;
         if (clrWrite)
            memWrite <= 1'b0;
         else if (setWrite)
            memWrite <= 1'b1;
      end
   end

   always_comb begin
      nextState     = state;
      pcWrite       = 1'b0;
      pcFromJump    = 1'b0;
      irWrite       = 1'b0;
      mdrWrite      = 1'b0;
      marWrite      = 1'b0;
      aWrite        = 1'b0;
      bWrite        = 1'b0;
      regWrite      = 1'b0;
      addrFromAlu   = 1'b0;
      aluSelA       = 1'b0;
      aluSelB       = mipsPkg::BSEL_REG;
      aluOp         = mipsPkg::ALU_ADD;
      signExtend    = 1'b1;
      regDstRd      = 1'b0;
      writeFromMem  = 1'b0;
      writeUpperImm = 1'b0;
      setRead       = 1'b0;
      clrRead       = 1'b0;
      setWrite      = 1'b0;
      clrWrite      = 1'b0;

      case (state)
         S_FETCH0: begin   // MAR <- PC, start the read
            marWrite  = 1'b1;
            setRead   = 1'b1;
            nextState = S_FETCH1;
         end
         S_FETCH1: nextState = S_FETCH2;
         S_FETCH2: nextState = S_FETCH3;
         S_FETCH3: begin
            irWrite   = 1'b1;
            pcWrite   = 1'b1;   // PC + 4
            aluSelB   = mipsPkg::BSEL_FOUR;
            clrRead   = 1'b1;
            nextState = S_DECODE;
         end

         S_DECODE: begin
            aWrite = 1'b1;
            bWrite = 1'b1;
            case (opcode)
               mipsPkg::OP_RTYPE: nextState = functKnown ? S_ALU_R : S_FETCH0;
               mipsPkg::OP_ADDI, mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI,
               mipsPkg::OP_SLTIU, mipsPkg::OP_ANDI, mipsPkg::OP_ORI,
               mipsPkg::OP_XORI, mipsPkg::OP_LUI: nextState = S_ALU_I;
               mipsPkg::OP_LW:    nextState = S_LOAD1;
               mipsPkg::OP_SW:    nextState = S_STORE1;
               mipsPkg::OP_BEQ,
               mipsPkg::OP_BNE:   nextState = S_BRANCH_CMP;
               mipsPkg::OP_J:     nextState = S_JUMP;
               default:           nextState = S_FETCH0;
            endcase
         end

         S_ALU_R: begin
            aluSelA   = 1'b1;
            aluOp     = functOp;
            regDstRd  = 1'b1;
            regWrite  = 1'b1;
            marWrite  = 1'b1;
            setRead   = 1'b1;
            nextState = S_FETCH1;
         end
         S_ALU_I: begin
            aluSelA       = 1'b1;
            aluSelB       = mipsPkg::BSEL_IMM;
            aluOp         = immOp;
            signExtend    = immSigned;
            writeUpperImm = (opcode == mipsPkg::OP_LUI);
            regWrite      = 1'b1;
            marWrite      = 1'b1;
            setRead       = 1'b1;
            nextState     = S_FETCH1;
         end

         S_LOAD1: begin   // MAR <- A + offset
            aluSelA     = 1'b1;
            aluSelB     = mipsPkg::BSEL_IMM;
            marWrite    = 1'b1;
            addrFromAlu = 1'b1;
            setRead     = 1'b1;
            nextState   = S_LOAD2;
         end
         S_LOAD2: nextState = S_LOAD3;
         S_LOAD3: nextState = S_LOAD4;
         S_LOAD4: begin
            mdrWrite  = 1'b1;
            clrRead   = 1'b1;
            nextState = S_LOAD5;
         end
         S_LOAD5: begin
            writeFromMem = 1'b1;
            regWrite     = 1'b1;
            marWrite     = 1'b1;
            setRead      = 1'b1;
            nextState    = S_FETCH1;
         end

         S_STORE1: begin
            aluSelA     = 1'b1;
            aluSelB     = mipsPkg::BSEL_IMM;
            marWrite    = 1'b1;
            addrFromAlu = 1'b1;
            setWrite    = 1'b1;
            nextState   = S_STORE2;
         end
         S_STORE2: begin   // memory writes on this edge
            clrWrite  = 1'b1;
            marWrite  = 1'b1;
            setRead   = 1'b1;
            nextState = S_FETCH1;
         end

         S_BRANCH_CMP: begin
            aluSelA = 1'b1;
            aluOp   = mipsPkg::ALU_SUB;
            if ((opcode == mipsPkg::OP_BEQ) == aluZero) begin
               nextState = S_BRANCH_TGT;
            end else begin
               marWrite  = 1'b1;
               setRead   = 1'b1;
               nextState = S_FETCH1;
            end
         end
         S_BRANCH_TGT: begin   // PC and MAR both take PC + offset
            aluSelB     = mipsPkg::BSEL_IMM_SHIFT;
            pcWrite     = 1'b1;
            marWrite    = 1'b1;
            addrFromAlu = 1'b1;
            setRead     = 1'b1;
            nextState   = S_FETCH1;
         end

         S_JUMP: begin
            pcWrite    = 1'b1;
            pcFromJump = 1'b1;
            nextState  = S_FETCH0;
         end

         default: nextState = S_FETCH0;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
   input  wire                 clk,
   input  wire                 reset,
   output mipsPkg::word_t      memAddr,
   input  wire mipsPkg::word_t memReadData,
   output mipsPkg::word_t      memWriteData,
   output logic                memRead,
   output logic                memWrite
);

   // controller to datapath
   logic              pcWrite, pcFromJump, irWrite, mdrWrite;
   logic              marWrite, aWrite, bWrite, regWrite;
   logic              addrFromAlu, aluSelA, signExtend, regDstRd;
   logic              writeFromMem, writeUpperImm;
   mipsPkg::aluBSel_t aluSelB;
   mipsPkg::aluOp_t   aluOp;

   // datapath to controller
   mipsPkg::opcode_t  opcode;
   mipsPkg::funct_t   funct;
   logic              aluZero;

   mipsController ctrl (
      .clk           (clk),
      .reset         (reset),
      .opcode        (opcode),
      .funct         (funct),
      .aluZero       (aluZero),
      .pcWrite       (pcWrite),
      .pcFromJump    (pcFromJump),
      .irWrite       (irWrite),
      .mdrWrite      (mdrWrite),
      .marWrite      (marWrite),
      .aWrite        (aWrite),
      .bWrite        (bWrite),
      .regWrite      (regWrite),
      .addrFromAlu   (addrFromAlu),
      .aluSelA       (aluSelA),
      .aluSelB       (aluSelB),
      .aluOp         (aluOp),
      .signExtend    (signExtend),
      .regDstRd      (regDstRd),
      .writeFromMem  (writeFromMem),
      .writeUpperImm (writeUpperImm),
      .memRead       (memRead),
      .memWrite      (memWrite)
   );

   mipsDatapath datapath (
      .clk           (clk),
      .reset         (reset),
      .pcWrite       (pcWrite),
      .pcFromJump    (pcFromJump),
      .irWrite       (irWrite),
      .mdrWrite      (mdrWrite),
      .marWrite      (marWrite),
      .aWrite        (aWrite),
      .bWrite        (bWrite),
      .regWrite      (regWrite),
      .addrFromAlu   (addrFromAlu),
      .aluSelA       (aluSelA),
      .aluSelB       (aluSelB),
      .aluOp         (aluOp),
      .signExtend    (signExtend),
      .regDstRd      (regDstRd),
      .writeFromMem  (writeFromMem),
      .writeUpperImm (writeUpperImm),
      .opcode        (opcode),
      .funct         (funct),
      .aluZero       (aluZero),
      .memAddr       (memAddr),
      .memWriteData  (memWriteData),
      .memReadData   (memReadData)
   );

endmodule

`default_nettype wire

// File: rtl/mipsDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module mipsDatapath (
   input  wire                    clk,
   input  wire                    reset,
   // write enables
   input  wire                    pcWrite,
   input  wire                    pcFromJump,
   input  wire                    irWrite,
   input  wire                    mdrWrite,
   input  wire                    marWrite,
   input  wire                    aWrite,
   input  wire                    bWrite,
   input  wire                    regWrite,
   // selects
   input  wire                    addrFromAlu,
   input  wire                    aluSelA,
   input  wire mipsPkg::aluBSel_t aluSelB,
   input  wire mipsPkg::aluOp_t   aluOp,
   input  wire                    signExtend,
   input  wire                    regDstRd,
   input  wire                    writeFromMem,
   input  wire                    writeUpperImm,
   // status back to the controller
   output mipsPkg::opcode_t       opcode,
   output mipsPkg::funct_t        funct,
   output logic                   aluZero,
   // memory port
   output mipsPkg::word_t         memAddr,
   output mipsPkg::word_t         memWriteData,
   input  wire mipsPkg::word_t    memReadData
);

   mipsPkg::word_t    pc, ir, mdr, mar, regA, regB;
   mipsPkg::word_t    immExt, aluA, aluB, aluResult;
   mipsPkg::word_t    rfData1, rfData2;
   mipsPkg::word_t    writeData, jumpTarget;
   mipsPkg::regAddr_t writeAddr;

   // ====================================================================
   // state registers
   // ====================================================================
   assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

   always_ff @(posedge clk) begin
      if (reset)
         pc <= mipsPkg::RESET_PC;
      else if (pcWrite)
         pc <= pcFromJump ? jumpTarget : aluResult;
   end

   always_ff @(posedge clk) begin
      if (irWrite)  ir   <= memReadData;
      if (mdrWrite) mdr  <= memReadData;
      if (marWrite) mar  <= addrFromAlu ? aluResult : pc;   // data or instruction address
      if (aWrite)   regA <= rfData1;
      if (bWrite)   regB <= rfData2;
   end

   assign opcode       = ir[31:26];
   assign funct        = ir[5:0];
   assign memAddr      = mar;
   assign memWriteData = regB;   // sw data is rt

   // ====================================================================
   // operand and write-back muxes
   // ====================================================================
   assign immExt = signExtend ? {{16{ir[15]}}, ir[15:0]} : {16'b0, ir[15:0]};
   assign aluA   = aluSelA ? regA : pc;

   always_comb begin
      case (aluSelB)
         mipsPkg::BSEL_REG:  aluB = regB;
         mipsPkg::BSEL_FOUR: aluB = mipsPkg::PC_STEP;
         mipsPkg::BSEL_IMM:  aluB = immExt;
         default:            aluB = immExt << 2;   // branch offset in words
      endcase
   end

   assign writeAddr = regDstRd ? ir[15:11] : ir[20:16];
   assign writeData = writeFromMem  ? mdr :
                      writeUpperImm ? {ir[15:0], 16'b0} : aluResult;

   aluUnit alu (
      .a      (aluA),
      .b      (aluB),
      .op     (aluOp),
      .result (aluResult),
      .zero   (aluZero)
   );

   registerFile regFile (
      .clk         (clk),
      .readAddr1   (ir[25:21]),
      .readAddr2   (ir[20:16]),
      .readData1   (rfData1),
      .readData2   (rfData2),
      .writeEnable (regWrite),
      .writeAddr   (writeAddr),
      .writeData   (writeData)
   );

endmodule

`default_nettype wire

// File: rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

   // ====================================================================
   // field and word types
   // ====================================================================
   typedef logic [31:0] word_t;
   typedef logic [4:0]  regAddr_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;
   typedef logic [2:0]  aluOp_t;
   typedef logic [1:0]  aluBSel_t;

   // alu operation codes
   localparam aluOp_t ALU_ADD  = 3'b000;
   localparam aluOp_t ALU_SUB  = 3'b001;
   localparam aluOp_t ALU_SLT  = 3'b010;
   localparam aluOp_t ALU_SLTU = 3'b011;
   localparam aluOp_t ALU_AND  = 3'b100;
   localparam aluOp_t ALU_XOR  = 3'b101;
   localparam aluOp_t ALU_OR   = 3'b110;
   localparam aluOp_t ALU_NOR  = 3'b111;

   // alu B operand sources
   localparam aluBSel_t BSEL_REG       = 2'b00;
   localparam aluBSel_t BSEL_FOUR      = 2'b01;
   localparam aluBSel_t BSEL_IMM       = 2'b10;
   localparam aluBSel_t BSEL_IMM_SHIFT = 2'b11;

   // primary opcodes
   localparam opcode_t OP_RTYPE = 6'b000_000;
   localparam opcode_t OP_J     = 6'b000_010;
   localparam opcode_t OP_BEQ   = 6'b000_100;
   localparam opcode_t OP_BNE   = 6'b000_101;
   localparam opcode_t OP_ADDI  = 6'b001_000;
   localparam opcode_t OP_ADDIU = 6'b001_001;
   localparam opcode_t OP_SLTI  = 6'b001_010;
   localparam opcode_t OP_SLTIU = 6'b001_011;
   localparam opcode_t OP_ANDI  = 6'b001_100;
   localparam opcode_t OP_ORI   = 6'b001_101;
   localparam opcode_t OP_XORI  = 6'b001_110;
   localparam opcode_t OP_LUI   = 6'b001_111;
   localparam opcode_t OP_LW    = 6'b100_011;
   localparam opcode_t OP_SW    = 6'b101_011;

   // R-type function codes
   localparam funct_t FN_ADD  = 6'b100_000;
   localparam funct_t FN_ADDU = 6'b100_001;
   localparam funct_t FN_SUB  = 6'b100_010;
   localparam funct_t FN_SUBU = 6'b100_011;
   localparam funct_t FN_AND  = 6'b100_100;
   localparam funct_t FN_OR   = 6'b100_101;
   localparam funct_t FN_XOR  = 6'b100_110;
   localparam funct_t FN_NOR  = 6'b100_111;
   localparam funct_t FN_SLT  = 6'b101_010;
   localparam funct_t FN_SLTU = 6'b101_011;

   localparam word_t RESET_PC = 32'h0000_0000;
   localparam word_t PC_STEP  = 32'd4;

endpackage

`default_nettype wire

// File: rtl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
   input  wire                    clk,
   input  wire mipsPkg::regAddr_t readAddr1,
   input  wire mipsPkg::regAddr_t readAddr2,
   output mipsPkg::word_t         readData1,
   output mipsPkg::word_t         readData2,
   input  wire                    writeEnable,
   input  wire mipsPkg::regAddr_t writeAddr,
   input  wire mipsPkg::word_t    writeData
);

   mipsPkg::word_t regs [0:31];

   // $zero reads as zero whatever the array holds
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

   always_ff @(posedge clk) begin
      if (writeEnable && (writeAddr != '0))
         regs[writeAddr] <= writeData;
   end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# builds and runs the mipsCore simulation with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module mipsCoreTb \
   -Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Checks failed" "$LOG"; then
   echo "RESULT: FAIL"
   exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
   echo "RESULT: FAIL (no pass message in $LOG)"
   exit 1
fi
echo "RESULT: PASS"
exit 0

// File: testbench/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;

   localparam int MEM_WORDS  = 256;
   localparam int DATA_FIRST = 192;      // data region 0x300..0x3fc
   localparam int CHUNKS     = 70;
   localparam int WAIT_LIMIT = 40;       // cycles per strobe wait
   localparam int STEP_LIMIT = 400;
   localparam logic [15:0] DATA_TOP = 16'h0400;
   localparam mipsPkg::regAddr_t BASE_REG = 5'd9;

   logic           clk;
   logic           reset = 1'b1;
   mipsPkg::word_t memReadData = '0;
   mipsPkg::word_t memAddr, memWriteData;
   logic           memRead, memWrite;

   mipsPkg::word_t mem     [0:MEM_WORDS-1];   // memory seen by the core
   mipsPkg::word_t refMem  [0:MEM_WORDS-1];   // shadow memory, also the program image
   mipsPkg::word_t refRegs [0:31];
   mipsPkg::word_t refPc, refAddr, refData, haltPc;
   integer         seed = 32'hb667;
   int             progLen;

   mipsCore DUT (
      .clk          (clk),
      .reset        (reset),
      .memAddr      (memAddr),
      .memReadData  (memReadData),
      .memWriteData (memWriteData),
      .memRead      (memRead),
      .memWrite     (memWrite)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // image is copied in while reset is held
   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < MEM_WORDS; i++)
            mem[i] <= refMem[i];
      end else begin
         if (memRead)
            memReadData <= mem[memAddr[9:2]];
         if (memWrite)
            mem[memAddr[9:2]] <= memWriteData;
      end
   end

   // ====================================================================
   // checks and waits
   // ====================================================================
   task automatic abortRun(input string why);
      $display("ERROR at time %0t: %s", $time, why);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkWord(input string name, input mipsPkg::word_t actual,
                            input mipsPkg::word_t expected);
      if (actual !== expected) begin
         $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, actual, expected);
         $display("Checks failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic checkFlag(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("FAIL time=%0t signal=%s got=%b expected=%b", $time, name, actual, expected);
         $display("Checks failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic waitReadRise();
      int cycles;
      cycles = 0;
      while (memRead !== 1'b0) begin   // previous read still up
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            abortRun("memRead stuck high, the core stopped fetching");
      end
      cycles = 0;
      while (memRead !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            abortRun("no memRead within the timeout, the core stopped fetching");
      end
   endtask

   task automatic waitWriteRise();
      int cycles;
      cycles = 0;
      while (memWrite !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            abortRun("no memWrite for a store, the core stopped fetching");
      end
   endtask

   // ====================================================================
   // program generator
   // ====================================================================
   function automatic int unsigned randBelow(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [15:0] randDataOffset();
      return 16'(0 - 4 * (1 + randBelow(64)));   // negative, below DATA_TOP
   endfunction

   function automatic mipsPkg::word_t encodeR(input mipsPkg::regAddr_t rs,
         input mipsPkg::regAddr_t rt, input mipsPkg::regAddr_t rd, input mipsPkg::funct_t fn);
      return {mipsPkg::OP_RTYPE, rs, rt, rd, 5'b0, fn};
   endfunction

   function automatic mipsPkg::word_t encodeI(input mipsPkg::opcode_t op,
         input mipsPkg::regAddr_t rs, input mipsPkg::regAddr_t rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic mipsPkg::word_t encodeJ(input int index);
      return {mipsPkg::OP_J, 26'(index)};
   endfunction

   function automatic mipsPkg::word_t randomAluInstr();
      mipsPkg::regAddr_t rs, rt, rd;
      mipsPkg::funct_t   fn;
      mipsPkg::opcode_t  op;
      logic [15:0]       imm;
      rs  = mipsPkg::regAddr_t'(randBelow(9));
      rt  = mipsPkg::regAddr_t'(randBelow(9));
      rd  = mipsPkg::regAddr_t'(1 + randBelow(8));   // never the base register
      imm = 16'($random(seed));
      fn  = mipsPkg::FN_ADD;
      op  = mipsPkg::OP_ADDI;
      if (randBelow(2) == 0) begin
         case (randBelow(10))
            0: fn = mipsPkg::FN_ADD;
            1: fn = mipsPkg::FN_ADDU;
            2: fn = mipsPkg::FN_SUB;
            3: fn = mipsPkg::FN_SUBU;
            4: fn = mipsPkg::FN_AND;
            5: fn = mipsPkg::FN_OR;
            6: fn = mipsPkg::FN_XOR;
            7: fn = mipsPkg::FN_NOR;
            8: fn = mipsPkg::FN_SLT;
            default: fn = mipsPkg::FN_SLTU;
         endcase
         return encodeR(rs, rt, rd, fn);
      end
      case (randBelow(8))
         0: op = mipsPkg::OP_ADDI;
         1: op = mipsPkg::OP_ADDIU;
         2: op = mipsPkg::OP_SLTI;
         3: op = mipsPkg::OP_SLTIU;
         4: op = mipsPkg::OP_ANDI;
         5: op = mipsPkg::OP_ORI;
         6: op = mipsPkg::OP_XORI;
         default: op = mipsPkg::OP_LUI;
      endcase
      return encodeI(op, rs, rd, imm);
   endfunction

   task automatic emit(input mipsPkg::word_t instr);
      refMem[progLen] = instr;
      progLen++;
   endtask

   task automatic buildProgram();
      mipsPkg::word_t    instr;
      mipsPkg::regAddr_t r;
      // unused words hold opcode 0x3f, which the core does not decode
      for (int i = 0; i < MEM_WORDS; i++)
         refMem[i] = {16'hffff, 16'(i)};
      for (int i = DATA_FIRST; i < MEM_WORDS; i++)
         refMem[i] = $random(seed);
      progLen = 0;
      emit(encodeI(mipsPkg::OP_ADDI, 5'd0, BASE_REG, DATA_TOP));
      for (int k = 1; k <= 8; k++)
         emit(encodeI(mipsPkg::OP_LW, BASE_REG, mipsPkg::regAddr_t'(k), randDataOffset()));
      for (int c = 0; c < CHUNKS; c++) begin
         if (c == CHUNKS / 2) begin
            emit(encodeJ(progLen + 3));   // skips the next two
            emit(randomAluInstr());
            emit(randomAluInstr());
         end
         case (randBelow(8))
            0, 1, 2, 3: emit(randomAluInstr());
            4: begin
               r = mipsPkg::regAddr_t'(randBelow(9));
               emit(encodeI(mipsPkg::OP_SW, BASE_REG, r, randDataOffset()));
            end
            5: begin   // load, then store the same register elsewhere
               r = mipsPkg::regAddr_t'(1 + randBelow(8));
               emit(encodeI(mipsPkg::OP_LW, BASE_REG, r, randDataOffset()));
               emit(encodeI(mipsPkg::OP_SW, BASE_REG, r, randDataOffset()));
            end
            6: begin
               emit(encodeI(randBelow(2) == 0 ? mipsPkg::OP_BEQ : mipsPkg::OP_BNE,
                            mipsPkg::regAddr_t'(randBelow(9)),
                            mipsPkg::regAddr_t'(randBelow(9)),
                            16'(1 + randBelow(3))));
            end
            default: begin
               instr = randomAluInstr();
               r = (instr[31:26] == mipsPkg::OP_RTYPE) ? instr[15:11] : instr[20:16];
               emit(instr);
               emit(encodeI(mipsPkg::OP_SW, BASE_REG, r, randDataOffset()));
            end
         endcase
      end
      for (int k = 1; k <= 8; k++)
         emit(encodeI(mipsPkg::OP_SW, BASE_REG, mipsPkg::regAddr_t'(k), randDataOffset()));
      haltPc = mipsPkg::word_t'(progLen * 4);
      emit(encodeJ(progLen));   // jump to self ends the program
   endtask

   // ====================================================================
   // reference model, one instruction per call
   // ====================================================================
   function automatic void refStep(input mipsPkg::word_t instr);
      mipsPkg::opcode_t  op;
      mipsPkg::funct_t   fn;
      mipsPkg::regAddr_t rs, rt, rd, dest;
      mipsPkg::word_t    a, b, sext, zext, nextPc, result;
      logic              writes, toRd;
      op      = instr[31:26];
      fn      = instr[5:0];
      rs      = instr[25:21];
      rt      = instr[20:16];
      rd      = instr[15:11];
      a       = refRegs[rs];
      b       = refRegs[rt];
      sext    = {{16{instr[15]}}, instr[15:0]};
      zext    = {16'b0, instr[15:0]};
      nextPc  = refPc + mipsPkg::PC_STEP;
      result  = '0;
      writes  = 1'b1;
      toRd    = 1'b0;
      refAddr = a + sext;   // effective address for lw and sw
      refData = b;
      case (op)
         mipsPkg::OP_RTYPE: begin
            toRd = 1'b1;
            case (fn)
               mipsPkg::FN_ADD, mipsPkg::FN_ADDU: result = a + b;
               mipsPkg::FN_SUB, mipsPkg::FN_SUBU: result = a - b;
               mipsPkg::FN_AND:  result = a & b;
               mipsPkg::FN_OR:   result = a | b;
               mipsPkg::FN_XOR:  result = a ^ b;
               mipsPkg::FN_NOR:  result = ~(a | b);
               mipsPkg::FN_SLT:  result = {31'b0, $signed(a) < $signed(b)};
               mipsPkg::FN_SLTU: result = {31'b0, a < b};
               default:          writes = 1'b0;
            endcase
         end
         mipsPkg::OP_ADDI, mipsPkg::OP_ADDIU: result = a + sext;
         mipsPkg::OP_SLTI:  result = {31'b0, $signed(a) < $signed(sext)};
         mipsPkg::OP_SLTIU: result = {31'b0, a < sext};   // unsigned against sign-extended
         mipsPkg::OP_ANDI:  result = a & zext;
         mipsPkg::OP_ORI:   result = a | zext;
         mipsPkg::OP_XORI:  result = a ^ zext;
         mipsPkg::OP_LUI:   result = {instr[15:0], 16'b0};
         mipsPkg::OP_LW:    result = refMem[refAddr[9:2]];
         mipsPkg::OP_SW: begin
            writes = 1'b0;
            refMem[refAddr[9:2]] = b;
         end
         mipsPkg::OP_BEQ: begin
            writes = 1'b0;
            if (a == b)
               nextPc = nextPc + (sext << 2);
         end
         mipsPkg::OP_BNE: begin
            writes = 1'b0;
            if (a != b)
               nextPc = nextPc + (sext << 2);
         end
         mipsPkg::OP_J: begin
            writes = 1'b0;
            nextPc = {nextPc[31:28], instr[25:0], 2'b00};
         end
         default: writes = 1'b0;
      endcase
      dest = toRd ? rd : rt;
      if (writes && (dest != '0))
         refRegs[dest] = result;
      refPc = nextPc;
   endfunction

   // ====================================================================
   // stimulus and compare
   // ====================================================================
   initial begin
      mipsPkg::word_t instr;
      int             steps;
      buildProgram();
      for (int r = 0; r < 32; r++)
         refRegs[r] = '0;
      refPc = mipsPkg::RESET_PC;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      checkFlag("memRead", memRead, 1'b0);
      checkFlag("memWrite", memWrite, 1'b0);

      steps = 0;
      while (refPc != haltPc) begin
         if (steps == STEP_LIMIT)
            abortRun("program did not reach its final jump");
         waitReadRise();
         checkWord("memAddr(fetch)", memAddr, refPc);
         instr = refMem[refPc[9:2]];
         refStep(instr);
         if (instr[31:26] == mipsPkg::OP_LW) begin
            waitReadRise();
            checkWord("memAddr(load)", memAddr, refAddr);
         end else if (instr[31:26] == mipsPkg::OP_SW) begin
            waitWriteRise();
            checkWord("memAddr(store)", memAddr, refAddr);
            checkWord("memWriteData", memWriteData, refData);
         end
         steps++;
      end
      waitReadRise();   // fetch of the final jump
      checkWord("memAddr(fetch)", memAddr, haltPc);
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/mipsCore_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore_assertions (
   input wire                 clk,
   input wire                 reset,
   input wire mipsPkg::word_t memAddr,
   input wire                 memRead,
   input wire                 memWrite
);

   // ====================================================================
   // memory port strobes
   // ====================================================================
   readWriteExclusive: assert property (@(posedge clk) disable iff (reset)
      !(memRead && memWrite))
      else $error("memRead and memWrite high in the same cycle");

   // one write edge per store
   writeOneCycle: assert property (@(posedge clk) disable iff (reset)
      memWrite |=> !memWrite)
      else $error("memWrite held longer than one cycle");

   alignedAddress: assert property (@(posedge clk) disable iff (reset)
      (memRead || memWrite) |-> (memAddr[1:0] == 2'b00))
      else $error("memAddr %h is not word aligned", memAddr);

endmodule

bind mipsCore mipsCore_assertions memPortChecks (
   .clk      (clk),
   .reset    (reset),
   .memAddr  (memAddr),
   .memRead  (memRead),
   .memWrite (memWrite)
);

`default_nettype wire
